// File: hdl/gf2_mul_pkg.sv
// ====================
// Shared constants for the split GF(2) polynomial multiplier.
// Maps each limb unit number to the limb pair it multiplies
// and to the weight of its partial product.
// ====================
`default_nettype none

package gf2_mul_pkg;

	// Each operand is cut into this many limbs
	localparam int NUM_LIMBS = 3;

	// One unit for every limb-by-limb product
	localparam int NUM_PARTIALS = NUM_LIMBS * NUM_LIMBS;

	// Limb of operand a used by a unit
	function automatic int partial_a_index(input int unit_num);
		return unit_num / NUM_LIMBS;
	endfunction

	// Limb of operand b used by a unit
	function automatic int partial_b_index(input int unit_num);
		return unit_num % NUM_LIMBS;
	endfunction

	// Partial product sits at this weight, in units of one limb width
	function automatic int partial_weight(input int unit_num);
		return partial_a_index(unit_num) + partial_b_index(unit_num);
	endfunction

endpackage

`default_nettype wire

// File: hdl/limb_mul_if.sv
// ====================
// Link between one limb multiplier and its neighbours.
// Operand side is fed by the dispatcher, result side is
// drained by the recombiner.
// ====================
`timescale 1ns/1ps
`default_nettype none

interface limb_mul_if #(
	parameter int LIMB_WIDTH = 16
);

	// Operand side
	logic                      start_valid;
	logic                      start_ready;
	logic [LIMB_WIDTH-1:0]     a_limb;
	logic [LIMB_WIDTH-1:0]     b_limb;

	// Result side, product is twice the limb width
	logic                      res_valid;
	logic                      res_ready;
	logic [2*LIMB_WIDTH-1:0]   product;

	modport source (output start_valid, output a_limb, output b_limb, input start_ready);

	modport unit (
		input  start_valid, input a_limb, input b_limb, input res_ready,
		output start_ready, output res_valid, output product
	);

	modport sink (input res_valid, input product, output res_ready);

endinterface

`default_nettype wire

// File: hdl/operand_dispatch.sv
// ====================
// Takes an operand pair from the input port and starts all
// limb units at once, each with its own registered limb pair.
// ====================
`timescale 1ns/1ps
`default_nettype none

module operand_dispatch import gf2_mul_pkg::*; #(
	parameter int LIMB_WIDTH = 16
) (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              in_valid,
	output logic                             in_ready,
	input  wire  [NUM_LIMBS*LIMB_WIDTH-1:0]  a,
	input  wire  [NUM_LIMBS*LIMB_WIDTH-1:0]  b,
	limb_mul_if.source                       units [NUM_PARTIALS]
);

	logic [NUM_PARTIALS-1:0] all_ready;
	logic                    start_q;
	logic                    accept;

	// A pair already waiting to start blocks the next one
	assign in_ready = (&all_ready) && !start_q;
	assign accept   = in_valid && in_ready;

	// One-cycle start pulse after each accept
	always_ff @(posedge clk) begin
		if (rst) begin
			start_q <= 1'b0;
		end else begin
			start_q <= accept;
		end
	end

	for (genvar i = 0; i < NUM_PARTIALS; i++) begin : g_unit
		localparam int A_IDX = partial_a_index(i);
		localparam int B_IDX = partial_b_index(i);

		assign all_ready[i]         = units[i].start_ready;
		assign units[i].start_valid = start_q;

		// Limbs stay put until the next accept
		always_ff @(posedge clk) begin
			if (accept) begin
				units[i].a_limb <= a[A_IDX*LIMB_WIDTH +: LIMB_WIDTH];
				units[i].b_limb <= b[B_IDX*LIMB_WIDTH +: LIMB_WIDTH];
			end
		end
	end

	// Every unit must be idle when the broadcast start goes out
	a_start_when_ready: assert property (
		@(posedge clk) disable iff (rst)
		start_q |-> (all_ready == {NUM_PARTIALS{1'b1}})
	) else $error("start_valid raised on a busy limb unit");

endmodule

`default_nettype wire

// File: hdl/limb_clmul_unit.sv
// ====================
// Bit-serial carry-less multiplier for one limb pair.
// One bit of a_limb per cycle; the product is held until
// the result side takes it.
// ====================
`timescale 1ns/1ps
`default_nettype none

module limb_clmul_unit #(
	parameter int LIMB_WIDTH = 16
) (
	input  wire     clk,
	input  wire     rst,
	limb_mul_if.unit lm
);

	localparam int CNT_W = $clog2(LIMB_WIDTH + 1);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(LIMB_WIDTH - 1);

	logic                    start;
	logic                    busy;
	logic [CNT_W-1:0]        bit_cnt;
	logic [LIMB_WIDTH-1:0]   a_shift;
	logic [2*LIMB_WIDTH-1:0] b_shift;
	logic [2*LIMB_WIDTH-1:0] acc;

	assign start      = lm.start_valid && lm.start_ready;
	assign lm.product = acc;

	// Control: idle -> busy for LIMB_WIDTH cycles -> result held
	always_ff @(posedge clk) begin
		if (rst) begin
			lm.start_ready <= 1'b1;
			lm.res_valid   <= 1'b0;
			busy           <= 1'b0;
			bit_cnt        <= '0;
		end else if (start) begin
			lm.start_ready <= 1'b0;
			busy           <= 1'b1;
			bit_cnt        <= '0;
		end else if (busy) begin
			// Counter advances once per bit, on every path
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == LAST_BIT) begin
				busy         <= 1'b0;
				lm.res_valid <= 1'b1;
			end
		end else if (lm.res_valid && lm.res_ready) begin
			lm.res_valid   <= 1'b0;
			lm.start_ready <= 1'b1;
		end
	end

	// Shift-and-XOR datapath
	always_ff @(posedge clk) begin
		if (start) begin
			a_shift <= lm.a_limb;
			b_shift <= {{LIMB_WIDTH{1'b0}}, lm.b_limb};
			acc     <= '0;
		end else if (busy) begin
			if (a_shift[0]) begin
				acc <= acc ^ b_shift;
			end
			a_shift <= a_shift >> 1;
			b_shift <= b_shift << 1;
		end
	end

	// Held result must not move before the recombiner takes it
	a_product_hold: assert property (
		@(posedge clk) disable iff (rst)
		(lm.res_valid && !lm.res_ready) |=> $stable(lm.product)
	) else $error("limb product changed while waiting for res_ready");

endmodule

`default_nettype wire

// File: hdl/product_recombine.sv
// ====================
// Gathers the nine partial products, XORs them at their limb
// weights into the output register and offers the result.
// ====================
`timescale 1ns/1ps
`default_nettype none

module product_recombine import gf2_mul_pkg::*; #(
	parameter int LIMB_WIDTH = 16
) (
	input  wire                                clk,
	input  wire                                rst,
	limb_mul_if.sink                           units [NUM_PARTIALS],
	output logic                               out_valid,
	input  wire                                out_ready,
	output logic [2*NUM_LIMBS*LIMB_WIDTH-1:0]  c
);

	localparam int PROD_W = 2 * NUM_LIMBS * LIMB_WIDTH;

	logic [NUM_PARTIALS-1:0] all_valid;
	logic [PROD_W-1:0]       weighted [NUM_PARTIALS];
	logic [PROD_W-1:0]       sum;
	logic                    release_q;
	logic                    out_full;

	for (genvar i = 0; i < NUM_PARTIALS; i++) begin : g_part
		localparam int SHIFT = partial_weight(i) * LIMB_WIDTH;

		assign all_valid[i]       = units[i].res_valid;
		assign weighted[i]        = PROD_W'(units[i].product) << SHIFT;
		assign units[i].res_ready = release_q;
	end

	// Overlapping partials simply cancel or combine in GF(2)
	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_PARTIALS; i++) begin
			sum = sum ^ weighted[i];
		end
	end

	// Release pulse lasts one cycle; the units drop res_valid right after
	always_ff @(posedge clk) begin
		if (rst) begin
			release_q <= 1'b0;
		end else begin
			release_q <= (&all_valid) && !out_full && !release_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_full <= 1'b0;
		end else if (release_q) begin
			out_full <= 1'b1;
		end else if (out_full && out_ready) begin
			out_full <= 1'b0;
		end
	end

	// Loaded in the release cycle, while the partials are still held
	always_ff @(posedge clk) begin
		if (release_q) begin
			c <= sum;
		end
	end

	assign out_valid = out_full;

	// Output must wait unchanged for the consumer
	a_out_hold: assert property (
		@(posedge clk) disable iff (rst)
		(out_full && !out_ready) |=> (out_full && $stable(c))
	) else $error("c changed while out_valid waited for out_ready");

endmodule

`default_nettype wire

// File: hdl/gf2_split_mul.sv
// ====================
// Carry-less GF(2) polynomial multiplier, three limbs per operand.
// Valid/ready on both sides; c is twice the operand width.
// ====================
`timescale 1ns/1ps
`default_nettype none

module gf2_split_mul import gf2_mul_pkg::*; #(
	parameter int LIMB_WIDTH = 16
) (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                in_valid,
	output logic                               in_ready,
	input  wire  [NUM_LIMBS*LIMB_WIDTH-1:0]    a,
	input  wire  [NUM_LIMBS*LIMB_WIDTH-1:0]    b,
	output logic                               out_valid,
	input  wire                                out_ready,
	output logic [2*NUM_LIMBS*LIMB_WIDTH-1:0]  c
);

	// One link per limb unit
	limb_mul_if #(
		.LIMB_WIDTH (LIMB_WIDTH)
	) lm_if [NUM_PARTIALS] ();

	operand_dispatch #(
		.LIMB_WIDTH (LIMB_WIDTH)
	) u_dispatch (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.a        (a),
		.b        (b),
		.units    (lm_if)
	);

	// All nine limb products run side by side
	for (genvar g = 0; g < NUM_PARTIALS; g++) begin : g_limb
		limb_clmul_unit #(
			.LIMB_WIDTH (LIMB_WIDTH)
		) u_unit (
			.clk (clk),
			.rst (rst),
			.lm  (lm_if[g])
		);
	end

	product_recombine #(
		.LIMB_WIDTH (LIMB_WIDTH)
	) u_recombine (
		.clk       (clk),
		.rst       (rst),
		.units     (lm_if),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.c         (c)
	);

endmodule

`default_nettype wire

// File: testbench/tb_gf2_split_mul.sv
// ====================
// Self-checking testbench for the split GF(2) multiplier.
// Reads operand pairs and expected products from the stimulus file.
// Run from the project root so the file path resolves.
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_gf2_split_mul import gf2_mul_pkg::*; ();

	localparam int LIMB_WIDTH     = 16;
	localparam int OP_W           = NUM_LIMBS * LIMB_WIDTH;
	localparam int PROD_W         = 2 * OP_W;
	localparam int NUM_VECTORS    = 18;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int HOLD_CYCLES    = 3 * LIMB_WIDTH;

	// Ways of driving out_ready
	localparam int READY_HOLD   = 0;
	localparam int READY_ALWAYS = 1;
	localparam int READY_RANDOM = 2;

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic              in_ready;
	logic [OP_W-1:0]   a;
	logic [OP_W-1:0]   b;
	logic              out_valid;
	logic              out_ready = 1'b0;
	logic [PROD_W-1:0] c;

	// Three words per vector: a, b, expected c
	logic [PROD_W-1:0] stim_mem [0:3*NUM_VECTORS-1];
	logic [PROD_W-1:0] expected_q [$];
	int                ready_mode;
	logic [31:0]       rng_state = 32'h71e0de92;

	gf2_split_mul #(
		.LIMB_WIDTH (LIMB_WIDTH)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.c         (c)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [OP_W-1:0] operand_a(input int idx);
		return stim_mem[3*idx][OP_W-1:0];
	endfunction

	function automatic logic [OP_W-1:0] operand_b(input int idx);
		return stim_mem[3*idx+1][OP_W-1:0];
	endfunction

	function automatic logic [PROD_W-1:0] expected_product(input int idx);
		return stim_mem[3*idx+2];
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_product(input string name, input logic [PROD_W-1:0] expected,
			input logic [PROD_W-1:0] actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("MISMATCH t=%0t %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic compare_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("MISMATCH t=%0t %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	// Mode changes on the rising edge, the output side reads it on the falling edge
	task automatic set_ready_mode(input int mode);
		@(posedge clk);
		ready_mode = mode;
		@(negedge clk);
	endtask

	// Called on a falling edge; returns on the falling edge after the transfer
	task automatic send_pair(input int idx);
		int waited;
		waited = 0;
		a        = operand_a(idx);
		b        = operand_b(idx);
		in_valid = 1'b1;
		while (!in_ready) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				stop_on_error($sformatf("timeout: operand pair %0d never accepted", idx));
			end
		end
		expected_q.push_back(expected_product(idx));
		@(negedge clk);
	endtask

	task automatic await_out_valid();
		int waited;
		waited = 0;
		while (!out_valid) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				stop_on_error("timeout: out_valid never rose");
			end
		end
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (expected_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				stop_on_error("timeout: pending results were not delivered");
			end
		end
	endtask

	// Output side: chooses out_ready and checks each result about to transfer
	always @(negedge clk) begin : output_side
		logic take;
		if (rst) begin
			out_ready = 1'b0;
		end else begin
			case (ready_mode)
				READY_ALWAYS: take = 1'b1;
				READY_RANDOM: begin
					rng_state = xorshift32(rng_state);
					take      = (rng_state[1:0] != 2'b00);
				end
				default: take = 1'b0;
			endcase
			out_ready = take;
			if (out_valid && take) begin
				if (expected_q.size() == 0) begin
					stop_on_error("a result appeared with no operand pair pending");
				end
				check_product("c", expected_q.pop_front(), c);
			end
		end
	end

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		in_valid   = 1'b0;
		a          = '0;
		b          = '0;
		ready_mode = READY_HOLD;
		$readmemh("testbench/gf2_mul_stimulus.hex", stim_mem);

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		compare_flag("out_valid", 1'b0, out_valid);
		compare_flag("in_ready", 1'b1, in_ready);

		// One pair at a time, consumer always ready
		set_ready_mode(READY_ALWAYS);
		for (int i = 0; i < NUM_VECTORS; i++) begin
			send_pair(i);
			in_valid = 1'b0;
			drain_results();
		end

		// Consumer stalled: first result waits while the second fills the units
		set_ready_mode(READY_HOLD);
		send_pair(14);
		in_valid = 1'b0;
		await_out_valid();
		send_pair(15);
		a        = operand_a(16);
		b        = operand_b(16);
		in_valid = 1'b1;
		for (int n = 0; n < HOLD_CYCLES; n++) begin
			compare_flag("out_valid", 1'b1, out_valid);
			compare_flag("in_ready", 1'b0, in_ready);
			check_product("c", expected_product(14), c);
			@(negedge clk);
		end
		set_ready_mode(READY_ALWAYS);
		send_pair(16);
		in_valid = 1'b0;
		drain_results();

		// Back-to-back pairs against a randomly stalling consumer
		set_ready_mode(READY_RANDOM);
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < NUM_VECTORS; i++) begin
				send_pair(i);
			end
		end
		in_valid = 1'b0;
		drain_results();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/gf2_mul_stimulus.hex
// Columns: operand a (48 bit), operand b (48 bit), expected carry-less product c (96 bit)
// All values hex, one operand pair per line, for LIMB_WIDTH 16
000000000000 123456789ABC 000000000000000000000000
FFFFFFFFFFFF 000000000000 000000000000000000000000
000000000001 123456789ABC 000000000000123456789ABC
FEDCBA987654 000000000001 000000000000FEDCBA987654
FFFFFFFFFFFF FFFFFFFFFFFF 555555555555555555555555
800080008000 800080008000 400000004000000040000000
800080008000 000000000001 000000000000800080008000
000000008000 800000000000 000000004000000000000000
000080000000 000000008000 000000000000400000000000
800000000000 800000000000 400000000000000000000000
000000000003 FFFFFFFFFFFF 000000000001000000000001
800000000000 FFFFFFFFFFFF 7FFFFFFFFFFF800000000000
00000000000B 00000000000D 00000000000000000000007F
0000000000FF 0000000000FF 000000000000000000005555
123456789ABC 123456789ABC 010405101114154041444550
FEDCBA987654 FEDCBA987654 555451504544414015141110
000100010001 123456789ABC 00001234444CDEF0CCC49ABC
000000000005 000000000005 000000000000000000000011

// File: gf2_split_mul.f
hdl/gf2_mul_pkg.sv
hdl/limb_mul_if.sv
hdl/operand_dispatch.sv
hdl/limb_clmul_unit.sv
hdl/product_recombine.sv
hdl/gf2_split_mul.sv
testbench/tb_gf2_split_mul.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gf2_split_mul \
	-f gf2_split_mul.f \
	-o sim_gf2_split_mul \
	&& ./obj_dir/sim_gf2_split_mul | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
